// ==== vlog.f ====
design/mips_pkg.sv
design/mips_sequencer.sv
design/mips_pc_unit.sv
design/mips_decoder.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_bus_unit.sv
design/mips_cpu_bus.sv
dv/mips_cpu_bus_properties.sv
dv/mips_tb.sv

// ==== Bender.yml ====
package:
  name: mips_cpu_bus

sources:
  - files:
      - design/mips_pkg.sv
      - design/mips_sequencer.sv
      - design/mips_pc_unit.sv
      - design/mips_decoder.sv
      - design/mips_regfile.sv
      - design/mips_alu.sv
      - design/mips_bus_unit.sv
      - design/mips_cpu_bus.sv
  - target: test
    files:
      - dv/mips_cpu_bus_properties.sv
      - dv/mips_tb.sv

// ==== dv/mips_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_tb;

    localparam mips_pkg::word_t RESET_VECTOR = 32'hbfc0_0000;
    localparam mips_pkg::word_t DATA_BASE    = 32'h0000_1000;
    localparam int NUM_TESTS   = 4;
    localparam int WATCHDOG_NS = NUM_TESTS * 64 * 3 * 4 * 20;   // 64 instr, 3 cycles, x4 stalls

    logic            clk = 1'b0;
    logic            reset;
    logic            waitrequest;
    mips_pkg::word_t readdata;
    mips_pkg::word_t readdata_next;
    logic            active;
    mips_pkg::word_t register_v0;
    mips_pkg::word_t address;
    logic            write;
    logic            read;
    mips_pkg::word_t writedata;
    logic [3:0]      byteenable;

    mips_pkg::word_t rom [64];   // Bus-order words at the reset vector
    mips_pkg::word_t dmem [16];  // Bus-order words at DATA_BASE
    mips_pkg::word_t exp_data [16];
    logic            exp_valid [16];
    int              prog_idx;
    int              seed = 32'he6cc;
    int              check_errors = 0;
    int              other_errors = 0;
    logic            stalled = 1'b0;
    mips_pkg::word_t held_address;
    logic            held_read;
    logic            held_write;

    mips_cpu_bus #(.RESET_VECTOR(RESET_VECTOR)) u_mips_cpu_bus (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    always #10 clk = ~clk;

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] got,
                              input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            check_errors++;
        end
    endtask

    function automatic mips_pkg::word_t byte_swap(input mips_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic mips_pkg::word_t sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic mips_pkg::word_t zext(input logic [15:0] imm);
        return {16'h0000, imm};
    endfunction

    function automatic mips_pkg::word_t enc_r(input mips_pkg::funct_e fn, input int rs,
                                              input int rt, input int rd, input int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic mips_pkg::word_t enc_i(input mips_pkg::opcode_e op, input int rs,
                                              input int rt, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic mips_pkg::word_t enc_j(input mips_pkg::opcode_e op,
                                              input mips_pkg::word_t target);
        return {op, target[27:2]};
    endfunction

    function automatic mips_pkg::word_t addr_of(input int idx);
        return RESET_VECTOR + 32'(4 * idx);
    endfunction

    // Bus side memory, request taken on a rising edge with waitrequest low
    always @(posedge clk) begin
        if (!reset && !waitrequest) begin
            if (read || write) begin
                check_mask("byteenable", byteenable, 4'b1111);   // Whole words only
            end
            if (write) begin
                if (address[31:6] == DATA_BASE[31:6]) begin
                    dmem[address[5:2]] <= writedata;
                end else begin
                    $display("ERROR at %0t: write to unmapped address 0x%08h", $time, address);
                    other_errors++;
                end
            end
            if (read) begin
                if (address[31:8] == RESET_VECTOR[31:8]) begin
                    readdata_next <= rom[address[7:2]];
                end else if (address[31:6] == DATA_BASE[31:6]) begin
                    readdata_next <= dmem[address[5:2]];
                end else begin
                    readdata_next <= '0;
                end
            end
        end
        if (stalled) begin   // Request must not move while held off
            check_word("address", address, held_address);
            check_bit("read", read, held_read);
            check_bit("write", write, held_write);
        end
        stalled      = (read || write) && waitrequest && !reset;
        held_address = address;
        held_read    = read;
        held_write   = write;
    end

    always @(negedge clk) begin
        readdata    = readdata_next;
        waitrequest = (($random(seed) & 3) == 0);
    end

    task automatic new_program();
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;   // NOP
        end
        for (int i = 0; i < 16; i++) begin
            dmem[i]      = '0;
            exp_valid[i] = 1'b0;
        end
        prog_idx = 0;
    endtask

    task automatic emit(input mips_pkg::word_t w);
        rom[prog_idx] = byte_swap(w);
        prog_idx++;
    endtask

    task automatic load_const(input int rd, input mips_pkg::word_t value);
        emit(enc_i(mips_pkg::OP_LUI, 0, rd, value[31:16]));
        emit(enc_i(mips_pkg::OP_ORI, rd, rd, value[15:0]));
    endtask

    task automatic store_v0(input int k, input mips_pkg::word_t exp);
        emit(enc_i(mips_pkg::OP_SW, 0, 2, 32'h1000 + 4 * k));
        exp_data[k]  = exp;
        exp_valid[k] = 1'b1;
    endtask

    task automatic finish_program();
        emit(enc_r(mips_pkg::FN_JR, 0, 0, 0, 0));
        emit('0);   // Delay slot
    endtask

    task automatic run_program(input mips_pkg::word_t exp_v0);
        @(negedge clk);
        reset = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_bit("read", read, 1'b0);   // No request under reset
            check_bit("write", write, 1'b0);
        end
        reset = 1'b0;
        @(posedge clk);   // End of the first FETCH cycle
        check_bit("active", active, 1'b1);
        check_bit("read", read, 1'b1);
        check_bit("write", write, 1'b0);
        check_word("address", address, RESET_VECTOR);
        check_word("register_v0", register_v0, '0);
        while (active) @(negedge clk);
        repeat (20) begin   // Halted core stays quiet
            @(negedge clk);
            check_bit("active", active, 1'b0);
            check_bit("read", read, 1'b0);
            check_bit("write", write, 1'b0);
        end
        check_word("register_v0", register_v0, exp_v0);
        for (int k = 0; k < 16; k++) begin
            if (exp_valid[k]) begin
                check_word($sformatf("dmem[%0d]", k), dmem[k], byte_swap(exp_data[k]));
            end
        end
    endtask

    task automatic test_r_type();
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        a = 32'h8000_0f05;
        b = 32'h0000_0003;
        new_program();
        load_const(8, a);
        load_const(9, b);
        emit(enc_r(mips_pkg::FN_ADDU, 8, 9, 2, 0));
        store_v0(0, a + b);
        emit(enc_r(mips_pkg::FN_SUBU, 8, 9, 2, 0));
        store_v0(1, a - b);
        emit(enc_r(mips_pkg::FN_AND, 8, 9, 2, 0));
        store_v0(2, a & b);
        emit(enc_r(mips_pkg::FN_OR, 8, 9, 2, 0));
        store_v0(3, a | b);
        emit(enc_r(mips_pkg::FN_XOR, 8, 9, 2, 0));
        store_v0(4, a ^ b);
        emit(enc_r(mips_pkg::FN_SLT, 8, 9, 2, 0));
        store_v0(5, mips_pkg::word_t'($signed(a) < $signed(b)));
        emit(enc_r(mips_pkg::FN_SLTU, 8, 9, 2, 0));
        store_v0(6, mips_pkg::word_t'(a < b));
        emit(enc_r(mips_pkg::FN_SLL, 0, 8, 2, 4));
        store_v0(7, a << 4);
        emit(enc_r(mips_pkg::FN_SRL, 0, 8, 2, 4));
        store_v0(8, a >> 4);
        emit(enc_r(mips_pkg::FN_SRA, 0, 8, 2, 4));
        store_v0(9, mips_pkg::word_t'($signed(a) >>> 4));
        emit(enc_r(mips_pkg::FN_SLLV, 9, 8, 2, 0));   // Amount from rs
        store_v0(10, a << b[4:0]);
        emit(enc_r(mips_pkg::FN_SRLV, 9, 8, 2, 0));
        store_v0(11, a >> b[4:0]);
        emit(enc_r(mips_pkg::FN_SRAV, 9, 8, 2, 0));
        store_v0(12, mips_pkg::word_t'($signed(a) >>> b[4:0]));
        finish_program();
        run_program(mips_pkg::word_t'($signed(a) >>> b[4:0]));
    endtask

    task automatic test_i_type();
        mips_pkg::word_t a;
        a = 32'h8000_00f0;
        new_program();
        load_const(8, a);
        emit(enc_i(mips_pkg::OP_ANDI, 8, 2, 16'h80ff));
        store_v0(0, a & zext(16'h80ff));
        emit(enc_i(mips_pkg::OP_ORI, 8, 2, 16'h8001));
        store_v0(1, a | zext(16'h8001));
        emit(enc_i(mips_pkg::OP_XORI, 8, 2, 16'hffff));
        store_v0(2, a ^ zext(16'hffff));
        emit(enc_i(mips_pkg::OP_ADDIU, 8, 2, 16'hfff0));
        store_v0(3, a + sext(16'hfff0));
        emit(enc_i(mips_pkg::OP_SLTI, 8, 2, 16'hffff));
        store_v0(4, mips_pkg::word_t'($signed(a) < $signed(sext(16'hffff))));
        emit(enc_i(mips_pkg::OP_SLTIU, 8, 2, 16'hffff));
        store_v0(5, mips_pkg::word_t'(a < sext(16'hffff)));
        emit(enc_i(mips_pkg::OP_SLTIU, 8, 2, 16'h0005));
        store_v0(6, mips_pkg::word_t'(a < sext(16'h0005)));
        emit(enc_i(mips_pkg::OP_LUI, 0, 2, 16'h1234));
        finish_program();
        run_program(32'h1234_0000);
    endtask

    task automatic test_load_store();
        mips_pkg::word_t v;
        v = 32'h1122_3344;
        new_program();
        dmem[10] = 32'haabb_ccdd;   // Preloaded bus word
        load_const(10, v);
        emit(enc_i(mips_pkg::OP_SW, 0, 10, 32'h1020));
        exp_data[8]  = v;
        exp_valid[8] = 1'b1;
        emit(enc_i(mips_pkg::OP_LW, 0, 2, 32'h1020));
        store_v0(9, v);
        emit(enc_i(mips_pkg::OP_LW, 0, 11, 32'h1028));
        emit(enc_i(mips_pkg::OP_SW, 0, 11, 32'h102c));
        exp_data[11]  = byte_swap(32'haabb_ccdd);
        exp_valid[11] = 1'b1;
        finish_program();
        run_program(v);
    endtask

    task automatic test_branch_jump();
        int jal_idx;
        int jalr_idx;
        new_program();
        emit(enc_i(mips_pkg::OP_ADDIU, 0, 8, 5));
        emit(enc_i(mips_pkg::OP_ADDIU, 0, 9, 5));
        emit(enc_i(mips_pkg::OP_BEQ, 8, 9, 2));      // Taken
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 1));
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h100));
        emit(enc_i(mips_pkg::OP_BNE, 8, 9, 2));      // Not taken
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 2));
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 4));
        emit(enc_i(mips_pkg::OP_BGTZ, 8, 0, 2));     // Taken
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 8));
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h100));
        emit(enc_i(mips_pkg::OP_REGIMM, 8, 0, 2));   // BLTZ, not taken
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16));
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 32));
        store_v0(0, 32'd63);
        jal_idx = prog_idx;
        emit(enc_j(mips_pkg::OP_JAL, addr_of(jal_idx + 3)));
        emit('0);
        emit(enc_i(mips_pkg::OP_ADDIU, 31, 31, 16'h100));   // Skipped, would spoil the link
        emit(enc_r(mips_pkg::FN_ADDU, 31, 0, 2, 0));
        store_v0(1, addr_of(jal_idx) + 32'd8);
        jalr_idx = prog_idx + 2;
        load_const(11, addr_of(jalr_idx + 3));
        emit(enc_r(mips_pkg::FN_JALR, 11, 0, 2, 0));
        emit('0);
        emit(enc_i(mips_pkg::OP_ADDIU, 2, 2, 16'h100));
        finish_program();
        run_program(addr_of(jalr_idx) + 32'd8);
    endtask

    initial begin
        reset         = 1'b1;
        waitrequest   = 1'b0;
        readdata      = '0;
        readdata_next = '0;
        test_r_type();
        test_i_type();
        test_load_store();
        test_branch_jump();
        $display("errors: %0d value mismatches, %0d other", check_errors, other_errors);
        if (check_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before the core halted");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mips_cpu_bus_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_properties (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            active,
    input wire mips_pkg::word_t address,
    input wire logic            read,
    input wire logic            write,
    input wire logic            waitrequest
);

    no_read_and_write: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write high together");

    // Held request keeps address and strobes
    stable_when_waiting: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else $error("request changed under waitrequest");

    active_stays_low: assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else $error("active rose without reset");

    quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("bus request while halted");

endmodule

bind mips_cpu_bus mips_cpu_bus_properties u_properties (
    .clk(clk), .reset(reset), .active(active), .address(address),
    .read(read), .write(write), .waitrequest(waitrequest)
);

`default_nettype wire

// ==== design/mips_cpu_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hbfc0_0000
) (
    input  wire logic            clk,
    input  wire logic            reset,
    output logic                 active,
    output mips_pkg::word_t      register_v0,
    output mips_pkg::word_t      address,
    output logic                 write,
    output logic                 read,
    input  wire logic            waitrequest,
    output mips_pkg::word_t      writedata,
    output logic [3:0]           byteenable,
    input  wire mips_pkg::word_t readdata
);

    mips_pkg::state_e state;
    logic             advance;
    mips_pkg::word_t  pc;
    mips_pkg::instr_u instr;
    mips_pkg::ctrl_t  ctrl;
    mips_pkg::word_t  rs_data;
    mips_pkg::word_t  rt_data;
    mips_pkg::word_t  alu_b;
    logic [4:0]       alu_shamt;
    mips_pkg::word_t  alu_result;
    mips_pkg::word_t  load_data;
    mips_pkg::wb_t    wb;

    mips_sequencer u_sequencer (
        .clk, .reset, .waitrequest, .ctrl, .pc, .state, .advance, .active
    );

    mips_pc_unit #(.RESET_VECTOR(RESET_VECTOR)) u_pc_unit (
        .clk, .reset, .state, .advance, .ctrl, .rs_data, .rt_data, .pc
    );

    mips_decoder u_decoder (.instr, .ctrl);

    mips_regfile u_regfile (
        .clk, .reset, .rs_addr(instr.r.rs), .rt_addr(instr.r.rt), .wb,
        .rs_data, .rt_data, .register_v0
    );

    assign alu_b     = ctrl.src_b_imm ? ctrl.imm : rt_data;
    assign alu_shamt = ctrl.shift_by_shamt ? instr.r.shamt : rs_data[4:0];

    mips_alu u_alu (.op(ctrl.alu_op), .a(rs_data), .b(alu_b), .shamt(alu_shamt), .result(alu_result));

    mips_bus_unit u_bus_unit (
        .clk, .reset, .state, .active, .pc, .ctrl, .alu_result, .rt_data, .waitrequest,
        .readdata, .instr, .load_data, .address, .read, .write, .writedata, .byteenable
    );

    // Loads retire in WB, everything else on the last EXEC cycle
    assign wb.en   = ctrl.reg_write && advance &&
                     (ctrl.mem_read ? (state == mips_pkg::WB) : (state == mips_pkg::EXEC));
    assign wb.addr = ctrl.dest;
    assign wb.data = ctrl.mem_read ? load_data :
                     ctrl.link     ? pc + 32'd8 :   // pc is still the jump's own address
                                     alu_result;

endmodule

`default_nettype wire

// ==== design/mips_bus_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_bus_unit (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire mips_pkg::state_e state,
    input  wire logic             active,
    input  wire mips_pkg::word_t  pc,
    input  wire mips_pkg::ctrl_t  ctrl,
    input  wire mips_pkg::word_t  alu_result,
    input  wire mips_pkg::word_t  rt_data,
    input  wire logic             waitrequest,
    input  wire mips_pkg::word_t  readdata,
    output mips_pkg::instr_u      instr,
    output mips_pkg::word_t       load_data,
    output mips_pkg::word_t       address,
    output logic                  read,
    output logic                  write,
    output mips_pkg::word_t       writedata,
    output logic [3:0]            byteenable
);

    mips_pkg::word_t  rdata_swap;
    mips_pkg::instr_u instr_q;
    logic             instr_fresh;   // readdata holds the fetched word this cycle

    // Bus lanes are little-endian
    assign rdata_swap = {readdata[7:0], readdata[15:8], readdata[23:16], readdata[31:24]};
    assign load_data  = rdata_swap;
    assign writedata  = {rt_data[7:0], rt_data[15:8], rt_data[23:16], rt_data[31:24]};
    assign byteenable = 4'b1111;

    assign instr = instr_fresh ? mips_pkg::instr_u'(rdata_swap) : instr_q;

    // Requests follow the state, so they hold while waitrequest is high
    assign address = (state == mips_pkg::FETCH) ? pc : alu_result;
    assign read    = !reset && (((state == mips_pkg::FETCH) && active) ||
                                ((state == mips_pkg::EXEC) && ctrl.mem_read));
    assign write   = !reset && (state == mips_pkg::EXEC) && ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_fresh <= 1'b0;
        end else begin
            instr_fresh <= (state == mips_pkg::FETCH) && active && !waitrequest;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_fresh) begin
            instr_q <= rdata_swap;   // Kept through a stalled EXEC and WB
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  wire mips_pkg::alu_op_e op,
    input  wire mips_pkg::word_t   a,
    input  wire mips_pkg::word_t   b,
    input  wire logic [4:0]        shamt,
    output mips_pkg::word_t        result
);

    // Shifts act on b, which carries rt
    always_comb begin
        case (op)
            mips_pkg::ALU_ADD:  result = a + b;
            mips_pkg::ALU_SUB:  result = a - b;
            mips_pkg::ALU_AND:  result = a & b;
            mips_pkg::ALU_OR:   result = a | b;
            mips_pkg::ALU_XOR:  result = a ^ b;
            mips_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            mips_pkg::ALU_SLTU: result = {31'b0, a < b};
            mips_pkg::ALU_SLL:  result = b << shamt;
            mips_pkg::ALU_SRL:  result = b >> shamt;
            mips_pkg::ALU_SRA:  result = $unsigned($signed(b) >>> shamt);
            mips_pkg::ALU_LUI:  result = {b[15:0], 16'b0};
            default:            result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire mips_pkg::reg_addr_t rs_addr,
    input  wire mips_pkg::reg_addr_t rt_addr,
    input  wire mips_pkg::wb_t      wb,
    output mips_pkg::word_t         rs_data,
    output mips_pkg::word_t         rt_data,
    output mips_pkg::word_t         register_v0
);

    mips_pkg::word_t regs [32];

    assign rs_data     = regs[rs_addr];
    assign rt_data     = regs[rt_addr];
    assign register_v0 = regs[2];   // $v0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin   // r0 stays zero
            regs[wb.addr] <= wb.data;
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decoder (
    input  wire mips_pkg::instr_u instr,
    output mips_pkg::ctrl_t       ctrl
);

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = mips_pkg::ALU_ADD;
        ctrl.branch = mips_pkg::BR_NONE;
        ctrl.dest   = instr.i.rt;   // I-type default target

        case (instr.r.opcode)
            mips_pkg::OP_SPECIAL: begin
                ctrl.dest      = instr.r.rd;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLLV: ctrl.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRLV: ctrl.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRAV: ctrl.alu_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
                        ctrl.shift_by_shamt = 1'b1;
                        ctrl.alu_op = (instr.r.funct == mips_pkg::FN_SLL) ? mips_pkg::ALU_SLL :
                                      (instr.r.funct == mips_pkg::FN_SRL) ? mips_pkg::ALU_SRL :
                                                                            mips_pkg::ALU_SRA;
                    end
                    mips_pkg::FN_JR: begin
                        ctrl.jump_reg  = 1'b1;
                        ctrl.reg_write = 1'b0;
                    end
                    mips_pkg::FN_JALR: begin
                        ctrl.jump_reg = 1'b1;
                        ctrl.link     = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;   // Unsupported funct is a no-op
                endcase
            end
            mips_pkg::OP_REGIMM: begin
                if (instr.i.rt == 5'd0) begin
                    ctrl.branch = mips_pkg::BR_LTZ;
                end else if (instr.i.rt == 5'd1) begin
                    ctrl.branch = mips_pkg::BR_GEZ;
                end
            end
            mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                ctrl.jump_imm  = 1'b1;
                ctrl.link      = (instr.j.opcode == mips_pkg::OP_JAL);
                ctrl.reg_write = ctrl.link;
                ctrl.dest      = 5'd31;
            end
            mips_pkg::OP_BEQ:  ctrl.branch = mips_pkg::BR_EQ;
            mips_pkg::OP_BNE:  ctrl.branch = mips_pkg::BR_NE;
            mips_pkg::OP_BLEZ: ctrl.branch = mips_pkg::BR_LEZ;
            mips_pkg::OP_BGTZ: ctrl.branch = mips_pkg::BR_GTZ;
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                case (instr.i.opcode)
                    mips_pkg::OP_SLTI:  ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_SLTIU: ctrl.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::OP_ANDI:  ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:   ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::OP_XORI:  ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::OP_LUI:   ctrl.alu_op = mips_pkg::ALU_LUI;
                    default:            ctrl.alu_op = mips_pkg::ALU_ADD;
                endcase
                ctrl.imm_zero_ext = (ctrl.alu_op == mips_pkg::ALU_AND) ||
                                    (ctrl.alu_op == mips_pkg::ALU_OR) ||
                                    (ctrl.alu_op == mips_pkg::ALU_XOR);
            end
            mips_pkg::OP_LW: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_pkg::OP_SW: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: ;
        endcase

        // J-type keeps its word index, the rest get a 16-bit immediate
        if (ctrl.jump_imm) begin
            ctrl.imm = {4'b0, instr.j.target, 2'b00};
        end else if (ctrl.imm_zero_ext) begin
            ctrl.imm = {16'b0, instr.i.imm};
        end else begin
            ctrl.imm = {{16{instr.i.imm[15]}}, instr.i.imm};
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pc_unit #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hbfc0_0000
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire mips_pkg::state_e state,
    input  wire logic             advance,
    input  wire mips_pkg::ctrl_t  ctrl,
    input  wire mips_pkg::word_t  rs_data,
    input  wire mips_pkg::word_t  rt_data,
    output mips_pkg::word_t       pc
);

    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t target;
    mips_pkg::word_t pending_target;
    logic            pending_valid;   // Current instruction sits in a delay slot
    logic            cond;
    logic            taken;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.branch)
            mips_pkg::BR_EQ:  cond = (rs_data == rt_data);
            mips_pkg::BR_NE:  cond = (rs_data != rt_data);
            mips_pkg::BR_LEZ: cond = ($signed(rs_data) <= 0);
            mips_pkg::BR_GTZ: cond = ($signed(rs_data) > 0);
            mips_pkg::BR_LTZ: cond = rs_data[31];
            mips_pkg::BR_GEZ: cond = !rs_data[31];
            default:          cond = 1'b0;
        endcase
    end

    assign taken = cond || ctrl.jump_imm || ctrl.jump_reg;

    always_comb begin
        if (ctrl.jump_reg) begin
            target = rs_data;
        end else if (ctrl.jump_imm) begin
            target = {pc_plus4[31:28], ctrl.imm[27:0]};   // Region of the delay slot
        end else begin
            target = pc_plus4 + {ctrl.imm[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc            <= RESET_VECTOR;
            pending_valid <= 1'b0;
        end else if (state == mips_pkg::EXEC && advance) begin
            if (pending_valid) begin
                pc            <= pending_target;
                pending_valid <= 1'b0;
            end else begin
                pc            <= pc_plus4;
                pending_valid <= taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == mips_pkg::EXEC && advance && !pending_valid) begin
            pending_target <= target;
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_sequencer (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            waitrequest,
    input  wire mips_pkg::ctrl_t ctrl,
    input  wire mips_pkg::word_t pc,
    output mips_pkg::state_e     state,
    output logic                 advance,
    output logic                 active
);

    logic mem_access;

    assign mem_access = ctrl.mem_read || ctrl.mem_write;

    // A state moves on once its request is taken, or at once if it has none
    always_comb begin
        case (state)
            mips_pkg::FETCH: advance = active && !waitrequest;
            mips_pkg::EXEC:  advance = mem_access ? !waitrequest : 1'b1;
            default:         advance = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= mips_pkg::FETCH;
            active <= 1'b1;
        end else if (advance) begin
            case (state)
                mips_pkg::FETCH: state <= mips_pkg::EXEC;
                mips_pkg::EXEC:  state <= mips_pkg::WB;
                default: begin
                    state <= mips_pkg::FETCH;
                    // pc already holds the next fetch address here
                    if (pc == '0) begin
                        active <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Three field layouts of one instruction word
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL  = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ = 6'h07,
        OP_ADDIU   = 6'h09, OP_SLTI   = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI = 6'h0c,
        OP_ORI     = 6'h0d, OP_XORI   = 6'h0e, OP_LUI   = 6'h0f, OP_LW   = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09,
        FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND  = 6'h24, FN_OR   = 6'h25,
        FN_XOR  = 6'h26, FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } branch_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src_b_imm;      // Operand b is the immediate
        logic      imm_zero_ext;
        logic      shift_by_shamt;
        logic      reg_write;
        reg_addr_t dest;
        logic      link;           // Write pc+8
        logic      mem_read;
        logic      mem_write;
        branch_e   branch;
        logic      jump_imm;
        logic      jump_reg;
        word_t     imm;            // Already extended
    } ctrl_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef enum logic [1:0] {
        FETCH, EXEC, WB
    } state_e;

endpackage

`default_nettype wire
